// File: hw/frontend_pkg.sv
/*
  frontend package
  address and page widths, link memory layout and the branch kinds
  shared by the fetch front end
*/
package frontend_pkg;

  localparam int ADDR_W      = 48;   // virtual fetch address
  localparam int PAGE_OFS_W  = 12;   // 4 KiB pages
  localparam int PPN_W       = 36;
  localparam int FETCH_BYTES = 16;   // one fetch block per cycle

  // link memory, translations low and spilled return addresses high
  localparam int LINK_AW = 7;
  localparam int LINK_W  = 48;
  localparam logic [LINK_AW-1:0] TRANS_BASE = 7'd0;
  localparam logic [LINK_AW-1:0] RAS_BASE   = 7'd64;

  typedef enum logic [1:0] {
    BR_COND = 2'd0,
    BR_JUMP = 2'd1,
    BR_CALL = 2'd2,
    BR_RET  = 2'd3
  } branch_kind_t;

endpackage

// File: hw/link_mem_if.sv
/*
  link memory interface
  one requester port of the shared link memory, seen from the
  requester, the arbiter and the memory
*/
`timescale 1ns/1ns

interface link_mem_if;
  import frontend_pkg::*;

  logic               req;
  logic               we;
  logic [LINK_AW-1:0] addr;
  logic [LINK_W-1:0]  wdata;
  logic               gnt;     // same cycle as req
  logic [LINK_W-1:0]  rdata;   // cycle after a granted read

  modport requester (output req, we, addr, wdata, input gnt, rdata);
  modport arbiter   (input req, we, addr, wdata, output gnt, rdata);
  modport memory    (input req, we, addr, wdata, output rdata);

endinterface

// File: hw/link_mem.sv
/*
  link memory
  single-port array shared by the page translation table and the
  return stack spill area, registered read
*/
`timescale 1ns/1ns

module link_mem (
  input logic        clk,
  link_mem_if.memory port
);
  import frontend_pkg::*;

  localparam int DEPTH = 1 << LINK_AW;

  logic [LINK_W-1:0] mem [DEPTH];

  always_ff @(posedge clk) begin
    if (port.req) begin
      if (port.we) begin
        mem[port.addr] <= port.wdata;
      end else begin
        port.rdata <= mem[port.addr];
      end
    end
  end

endmodule

// File: hw/link_arbiter.sv
/*
  link memory arbiter
  fixed priority, return stack first, page translator otherwise;
  read data goes back to whoever won the read
*/
`timescale 1ns/1ns

module link_arbiter (
  input logic           clk,
  input logic           rst,
  link_mem_if.arbiter   ras,
  link_mem_if.arbiter   trans,
  link_mem_if.requester mem
);

  logic ras_rd_q;   // last granted read belonged to the stack

  assign ras.gnt   = ras.req;
  assign trans.gnt = trans.req & ~ras.req;

  assign mem.req   = ras.req | trans.req;
  assign mem.we    = ras.req ? ras.we    : trans.we;
  assign mem.addr  = ras.req ? ras.addr  : trans.addr;
  assign mem.wdata = ras.req ? ras.wdata : trans.wdata;

  always_ff @(posedge clk) begin
    if (rst) begin
      ras_rd_q <= 1'b0;
    end else begin
      ras_rd_q <= ras.req & ~ras.we;
    end
  end

  // steer registered read data
  assign ras.rdata   = ras_rd_q ? mem.rdata : '0;
  assign trans.rdata = ras_rd_q ? '0 : mem.rdata;

endmodule

// File: hw/page_translator.sv
/*
  page translator
  untagged direct lookup of the fetch page in link memory, one
  pending translation write, fetch result paired with read data
*/
`timescale 1ns/1ns

module page_translator #(
  parameter int TRANS_IDX_W = 6
) (
  input  logic                                                clk,
  input  logic                                                rst,
  input  logic [frontend_pkg::ADDR_W-1:0]                     ip,
  input  logic                                                wr_valid,
  input  logic [frontend_pkg::ADDR_W-frontend_pkg::PAGE_OFS_W-1:0] wr_vpn,
  input  logic [frontend_pkg::PPN_W-1:0]                      wr_ppn,
  output logic                                                accept,
  output logic                                                fetch_valid,
  output logic [frontend_pkg::ADDR_W-1:0]                     fetch_ip,
  output logic [frontend_pkg::PPN_W+frontend_pkg::PAGE_OFS_W-1:0] fetch_pa,
  link_mem_if.requester                                       mem
);
  import frontend_pkg::*;

  logic                   wr_pend;
  logic [TRANS_IDX_W-1:0] wr_idx;
  logic [PPN_W-1:0]       wr_data;
  logic [TRANS_IDX_W-1:0] idx;
  logic [ADDR_W-1:0]      acc_ip;

  assign idx = wr_pend ? wr_idx : ip[PAGE_OFS_W +: TRANS_IDX_W];

  assign mem.req   = 1'b1;   // lookup every cycle
  assign mem.we    = wr_pend;
  assign mem.addr  = TRANS_BASE + LINK_AW'(idx);
  assign mem.wdata = LINK_W'(wr_data);

  assign accept = mem.gnt & ~wr_pend;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_pend     <= 1'b0;
      fetch_valid <= 1'b0;
    end else begin
      fetch_valid <= accept;
      if (wr_pend) begin
        wr_pend <= ~mem.gnt;   // new writes dropped meanwhile
      end else begin
        wr_pend <= wr_valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_valid && !wr_pend) begin
      wr_idx  <= wr_vpn[TRANS_IDX_W-1:0];
      wr_data <= wr_ppn;
    end
    if (accept) begin
      acc_ip <= ip;
    end
  end

  assign fetch_ip = acc_ip;
  assign fetch_pa = {mem.rdata[PPN_W-1:0], acc_ip[PAGE_OFS_W-1:0]};

endmodule

// File: hw/return_stack.sv
/*
  return stack
  top entry held in a register, older entries spilled to the
  stack region of link memory and refilled on return
*/
`timescale 1ns/1ns

module return_stack #(
  parameter int RAS_DEPTH_W = 4
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            push,
  input  logic [frontend_pkg::ADDR_W-1:0] push_addr,
  input  logic                            pop,
  output logic [frontend_pkg::ADDR_W-1:0] top,
  output logic                            busy,
  link_mem_if.requester                   mem
);
  import frontend_pkg::*;

  logic [RAS_DEPTH_W-1:0] ptr;
  logic [RAS_DEPTH_W-1:0] rd_ptr;
  logic                   spill_pend;   // write old top
  logic                   fill_pend;    // read entry below
  logic                   refill;       // read data arriving
  logic [ADDR_W-1:0]      top_q;
  logic [ADDR_W-1:0]      spill_q;

  assign rd_ptr = ptr - 1'b1;

  assign mem.req   = spill_pend | fill_pend;
  assign mem.we    = spill_pend;
  assign mem.addr  = RAS_BASE + LINK_AW'(spill_pend ? ptr : rd_ptr);
  assign mem.wdata = LINK_W'(spill_q);

  assign busy = spill_pend | fill_pend;
  assign top  = refill ? mem.rdata[ADDR_W-1:0] : top_q;   // bypass on refill

  always_ff @(posedge clk) begin
    if (rst) begin
      ptr        <= '0;
      spill_pend <= 1'b0;
      fill_pend  <= 1'b0;
      refill     <= 1'b0;
    end else begin
      spill_pend <= push;
      fill_pend  <= pop;
      refill     <= fill_pend;
      if (spill_pend) begin
        ptr <= ptr + 1'b1;
      end else if (fill_pend) begin
        ptr <= rd_ptr;   // wraps, no underflow check
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      top_q   <= push_addr;
      spill_q <= top;
    end else if (refill) begin
      top_q <= mem.rdata[ADDR_W-1:0];
    end
  end

endmodule

// File: hw/branch_target_buffer.sv
/*
  branch target buffer
  direct mapped, tagged with the upper address bits, returns
  target and branch kind, written by every retired branch
*/
`timescale 1ns/1ns

module branch_target_buffer #(
  parameter int BTB_IDX_W = 6
) (
  input  logic                             clk,
  input  logic                             rst,
  input  logic [frontend_pkg::ADDR_W-1:0]  lookup_ip,
  output logic                             hit,
  output frontend_pkg::branch_kind_t       kind,
  output logic [frontend_pkg::ADDR_W-1:0]  target,
  input  logic                             upd_valid,
  input  logic [frontend_pkg::ADDR_W-1:0]  upd_ip,
  input  frontend_pkg::branch_kind_t       upd_kind,
  input  logic [frontend_pkg::ADDR_W-1:0]  upd_target
);
  import frontend_pkg::*;

  localparam int OFS_W   = $clog2(FETCH_BYTES);
  localparam int TAG_W   = ADDR_W - OFS_W - BTB_IDX_W;
  localparam int ENTRIES = 1 << BTB_IDX_W;

  logic [ENTRIES-1:0] valid;
  logic [TAG_W-1:0]   tag_mem    [ENTRIES];
  branch_kind_t       kind_mem   [ENTRIES];
  logic [ADDR_W-1:0]  target_mem [ENTRIES];

  logic [BTB_IDX_W-1:0] rd_idx;
  logic [BTB_IDX_W-1:0] wr_idx;

  assign rd_idx = lookup_ip[OFS_W +: BTB_IDX_W];
  assign wr_idx = upd_ip[OFS_W +: BTB_IDX_W];

  assign hit    = valid[rd_idx] && (tag_mem[rd_idx] == lookup_ip[ADDR_W-1 -: TAG_W]);
  assign kind   = kind_mem[rd_idx];
  assign target = target_mem[rd_idx];

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
    end else if (upd_valid) begin
      valid[wr_idx] <= 1'b1;
    end
  end

  // entry payload, overwritten whole
  always_ff @(posedge clk) begin
    if (upd_valid) begin
      tag_mem[wr_idx]    <= upd_ip[ADDR_W-1 -: TAG_W];
      kind_mem[wr_idx]   <= upd_kind;
      target_mem[wr_idx] <= upd_target;
    end
  end

endmodule

// File: hw/direction_predictor.sv
/*
  direction predictor
  three single-bit tables combined by xor, indexed by address,
  address and history, and history alone; a mispredict flips one
  table bit, rotating A, B, C
*/
`timescale 1ns/1ns

module direction_predictor #(
  parameter int PRED_IDX_W = 8,
  parameter int HIST_W     = 8
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [frontend_pkg::ADDR_W-1:0] lookup_ip,
  output logic                            taken,
  output logic [HIST_W-1:0]               history,
  input  logic                            shift_valid,
  input  logic                            upd_valid,
  input  logic                            upd_cond,
  input  logic [frontend_pkg::ADDR_W-1:0] upd_ip,
  input  logic [HIST_W-1:0]               upd_history,
  input  logic                            upd_taken
);
  import frontend_pkg::*;

  localparam int OFS_W    = $clog2(FETCH_BYTES);
  localparam int HALF_W   = PRED_IDX_W / 2;
  localparam int TBL_SIZE = 1 << PRED_IDX_W;

  logic [TBL_SIZE-1:0]   tbl_a;
  logic [TBL_SIZE-1:0]   tbl_b;
  logic [TBL_SIZE-1:0]   tbl_c;
  logic [1:0]            rot;   // next table to train
  logic [PRED_IDX_W-1:0] la, lb, lc;
  logic [PRED_IDX_W-1:0] ua, ub, uc;

  function automatic logic [PRED_IDX_W-1:0] idx_a(input logic [ADDR_W-1:0] ip);
    return ip[OFS_W +: PRED_IDX_W];
  endfunction

  function automatic logic [PRED_IDX_W-1:0] idx_b(input logic [ADDR_W-1:0] ip,
                                                  input logic [HIST_W-1:0] hist);
    return {ip[OFS_W +: HALF_W], hist[PRED_IDX_W-HALF_W-1:0]};
  endfunction

  assign la = idx_a(lookup_ip);
  assign lb = idx_b(lookup_ip, history);
  assign lc = history[PRED_IDX_W-1:0];
  assign ua = idx_a(upd_ip);
  assign ub = idx_b(upd_ip, upd_history);
  assign uc = upd_history[PRED_IDX_W-1:0];

  assign taken = tbl_a[la] ^ tbl_b[lb] ^ tbl_c[lc];

  always_ff @(posedge clk) begin
    if (rst) begin
      tbl_a   <= '0;
      tbl_b   <= '0;
      tbl_c   <= '0;
      history <= '0;
      rot     <= 2'd0;
    end else if (upd_valid) begin
      history <= {upd_history[HIST_W-2:0], upd_taken};   // repair from retirement
      if (upd_cond) begin
        case (rot)
          2'd0:    tbl_a[ua] <= ~tbl_a[ua];
          2'd1:    tbl_b[ub] <= ~tbl_b[ub];
          default: tbl_c[uc] <= ~tbl_c[uc];
        endcase
        rot <= (rot == 2'd2) ? 2'd0 : rot + 2'd1;
      end
    end else if (shift_valid) begin
      history <= {history[HIST_W-2:0], taken};
    end
  end

endmodule

// File: hw/fetch_frontend.sv
/*
  fetch front end
  fetch address register and next address selection from the
  target buffer, direction predictor and return stack; redirects
  on mispredicted retirement
*/
`timescale 1ns/1ns

module fetch_frontend #(
  parameter int BTB_IDX_W   = 6,
  parameter int PRED_IDX_W  = 8,
  parameter int HIST_W      = PRED_IDX_W,
  parameter int TRANS_IDX_W = 6,
  parameter int RAS_DEPTH_W = 4
) (
  input  logic                                                clk,
  input  logic                                                rst,
  input  logic [frontend_pkg::ADDR_W-1:0]                     init_ip,
  input  logic                                                tlb_wr_valid,
  input  logic [frontend_pkg::ADDR_W-frontend_pkg::PAGE_OFS_W-1:0] tlb_wr_vpn,
  input  logic [frontend_pkg::PPN_W-1:0]                      tlb_wr_ppn,
  input  logic                                                ret_valid,
  input  logic [frontend_pkg::ADDR_W-1:0]                     ret_ip,
  input  frontend_pkg::branch_kind_t                          ret_kind,
  input  logic                                                ret_taken,
  input  logic [frontend_pkg::ADDR_W-1:0]                     ret_target,
  input  logic [HIST_W-1:0]                                   ret_history,
  input  logic                                                ret_mispred,
  output logic                                                fetch_valid,
  output logic [frontend_pkg::ADDR_W-1:0]                     fetch_ip,
  output logic [frontend_pkg::PPN_W+frontend_pkg::PAGE_OFS_W-1:0] fetch_pa
);
  import frontend_pkg::*;

  logic [ADDR_W-1:0] ip_q;
  logic [ADDR_W-1:0] seq_ip;
  logic [ADDR_W-1:0] next_ip;
  logic              accept;
  logic              redirect;
  logic              btb_hit;
  branch_kind_t      btb_kind;
  logic [ADDR_W-1:0] btb_target;
  logic              pred_taken;
  logic [ADDR_W-1:0] ras_top;
  logic              ras_busy;
  logic              stack_go;

  link_mem_if trans_link ();
  link_mem_if ras_link ();
  link_mem_if mem_link ();

  assign seq_ip   = ip_q + ADDR_W'(FETCH_BYTES);
  assign redirect = ret_valid & ret_mispred;
  assign stack_go = accept & btb_hit & ~ras_busy;

  always_comb begin
    next_ip = seq_ip;   // miss falls through
    if (btb_hit) begin
      case (btb_kind)
        BR_JUMP, BR_CALL: next_ip = btb_target;
        BR_RET:           next_ip = ras_top;
        BR_COND:          next_ip = pred_taken ? btb_target : seq_ip;
        default:          next_ip = seq_ip;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ip_q <= init_ip;
    end else if (redirect) begin
      ip_q <= ret_taken ? ret_target : ret_ip + ADDR_W'(FETCH_BYTES);
    end else if (accept) begin
      ip_q <= next_ip;
    end
  end

  page_translator #(
    .TRANS_IDX_W (TRANS_IDX_W)
  ) page_translator_inst (
    .clk         (clk),
    .rst         (rst),
    .ip          (ip_q),
    .wr_valid    (tlb_wr_valid),
    .wr_vpn      (tlb_wr_vpn),
    .wr_ppn      (tlb_wr_ppn),
    .accept      (accept),
    .fetch_valid (fetch_valid),
    .fetch_ip    (fetch_ip),
    .fetch_pa    (fetch_pa),
    .mem         (trans_link)
  );

  return_stack #(
    .RAS_DEPTH_W (RAS_DEPTH_W)
  ) return_stack_inst (
    .clk       (clk),
    .rst       (rst),
    .push      (stack_go && btb_kind == BR_CALL),
    .push_addr (seq_ip),   // return lands after the call block
    .pop       (stack_go && btb_kind == BR_RET),
    .top       (ras_top),
    .busy      (ras_busy),
    .mem       (ras_link)
  );

  branch_target_buffer #(
    .BTB_IDX_W (BTB_IDX_W)
  ) branch_target_buffer_inst (
    .clk        (clk),
    .rst        (rst),
    .lookup_ip  (ip_q),
    .hit        (btb_hit),
    .kind       (btb_kind),
    .target     (btb_target),
    .upd_valid  (ret_valid),
    .upd_ip     (ret_ip),
    .upd_kind   (ret_kind),
    .upd_target (ret_target)
  );

  direction_predictor #(
    .PRED_IDX_W (PRED_IDX_W),
    .HIST_W     (HIST_W)
  ) direction_predictor_inst (
    .clk         (clk),
    .rst         (rst),
    .lookup_ip   (ip_q),
    .taken       (pred_taken),
    .history     (),
    .shift_valid (accept && btb_hit && btb_kind == BR_COND),
    .upd_valid   (redirect),
    .upd_cond    (ret_kind == BR_COND),
    .upd_ip      (ret_ip),
    .upd_history (ret_history),
    .upd_taken   (ret_taken)
  );

  link_arbiter link_arbiter_inst (
    .clk   (clk),
    .rst   (rst),
    .ras   (ras_link),
    .trans (trans_link),
    .mem   (mem_link)
  );

  link_mem link_mem_inst (
    .clk  (clk),
    .port (mem_link)
  );

endmodule

// File: testbench/tb_fetch_frontend.sv
/*
  fetch front end testbench
  drives reset, translation writes and retirements, follows every
  fetch with a model of the target buffer, tables, history and
  return stack, and checks fetch_ip, fetch_pa and stack gaps
*/
`timescale 1ns/1ns

module tb_fetch_frontend;
  import frontend_pkg::*;

  localparam int BTB_IDX_W   = 6;
  localparam int PRED_IDX_W  = 8;
  localparam int HIST_W      = 8;
  localparam int TRANS_IDX_W = 6;
  localparam int RAS_DEPTH_W = 4;
  localparam int OFS_W       = $clog2(FETCH_BYTES);
  localparam int TAG_W       = ADDR_W - OFS_W - BTB_IDX_W;
  localparam int VPN_W       = ADDR_W - PAGE_OFS_W;
  localparam int HALF        = PRED_IDX_W / 2;

  localparam logic [ADDR_W-1:0] INIT_IP    = 48'h0000_0040_0100;
  localparam logic [ADDR_W-1:0] SCRATCH_IP = 48'h7000_0000_03f0;   // btb index 3f
  localparam logic [ADDR_W-1:0] JMP_IP     = 48'h0000_1000_0080;
  localparam logic [ADDR_W-1:0] JMP_TGT    = 48'h0000_2000_0040;
  localparam logic [ADDR_W-1:0] CALL_IP    = 48'h0000_3000_0300;
  localparam logic [ADDR_W-1:0] FUNC_IP    = 48'h0000_3000_0100;
  localparam logic [ADDR_W-1:0] RETN_IP    = 48'h0000_3000_0120;
  localparam logic [ADDR_W-1:0] COND_IP    = 48'h0000_5000_0240;
  localparam logic [ADDR_W-1:0] COND_TGT   = 48'h0000_6000_0000;

  logic                      clk = 1'b0;
  logic                      rst;
  logic [ADDR_W-1:0]         init_ip;
  logic                      tlb_wr_valid;
  logic [VPN_W-1:0]          tlb_wr_vpn;
  logic [PPN_W-1:0]          tlb_wr_ppn;
  logic                      ret_valid;
  logic [ADDR_W-1:0]         ret_ip;
  branch_kind_t              ret_kind;
  logic                      ret_taken;
  logic [ADDR_W-1:0]         ret_target;
  logic [HIST_W-1:0]         ret_history;
  logic                      ret_mispred;
  logic                      fetch_valid;
  logic [ADDR_W-1:0]         fetch_ip;
  logic [PPN_W+PAGE_OFS_W-1:0] fetch_pa;

  // model state
  bit                        btb_valid [1 << BTB_IDX_W];
  logic [TAG_W-1:0]          btb_tag [1 << BTB_IDX_W];
  branch_kind_t              btb_kind [1 << BTB_IDX_W];
  logic [ADDR_W-1:0]         btb_target [1 << BTB_IDX_W];
  bit [(1 << PRED_IDX_W)-1:0] tbl_a, tbl_b, tbl_c;
  logic [HIST_W-1:0]         m_hist = '0;
  int                        rot = 0;
  logic [ADDR_W-1:0]         ras_q [$];
  logic [PPN_W-1:0]          tlb_ppn [1 << TRANS_IDX_W];
  bit                        tlb_known [1 << TRANS_IDX_W];

  // checker state
  bit                        mon_on, synced, stack_prev;
  logic [ADDR_W-1:0]         exp_ip, sync_ip;
  int                        cyc = 0;
  int                        last_cyc, seen, checks, errors, pa_checks, gap_checks;
  int                        test_err0, pa0, g0, r;
  integer                    seed;
  logic [63:0]               rnd;
  logic [VPN_W-1:0]          vpn;

  fetch_frontend #(
    .BTB_IDX_W   (BTB_IDX_W),
    .PRED_IDX_W  (PRED_IDX_W),
    .HIST_W      (HIST_W),
    .TRANS_IDX_W (TRANS_IDX_W),
    .RAS_DEPTH_W (RAS_DEPTH_W)
  ) fetch_frontend_inst (
    .clk (clk), .rst (rst), .init_ip (init_ip),
    .tlb_wr_valid (tlb_wr_valid), .tlb_wr_vpn (tlb_wr_vpn), .tlb_wr_ppn (tlb_wr_ppn),
    .ret_valid (ret_valid), .ret_ip (ret_ip), .ret_kind (ret_kind),
    .ret_taken (ret_taken), .ret_target (ret_target), .ret_history (ret_history),
    .ret_mispred (ret_mispred),
    .fetch_valid (fetch_valid), .fetch_ip (fetch_ip), .fetch_pa (fetch_pa)
  );

  always #4 clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  task step;
    @(posedge clk);
    #1;
  endtask

  task table_indices(input logic [ADDR_W-1:0] ip, input logic [HIST_W-1:0] h,
                     output logic [PRED_IDX_W-1:0] ia, ib, ic);
    ia = ip[OFS_W +: PRED_IDX_W];
    ib = {ip[OFS_W +: HALF], h[HALF-1:0]};   // address half, history half
    ic = h;
  endtask

  // next fetch address from the model, history and stack advance with it
  task predict_next(input logic [ADDR_W-1:0] ip, output logic [ADDR_W-1:0] nxt,
                    output bit stk);
    int bi;
    logic [PRED_IDX_W-1:0] ia, ib, ic;
    logic tk;
    bi = ip[OFS_W +: BTB_IDX_W];
    nxt = ip + FETCH_BYTES;
    stk = 1'b0;
    if (btb_valid[bi] && btb_tag[bi] == ip[ADDR_W-1:OFS_W+BTB_IDX_W]) begin
      case (btb_kind[bi])
        BR_JUMP: nxt = btb_target[bi];
        BR_CALL: begin
          ras_q.push_back(nxt);
          nxt = btb_target[bi];
          stk = 1'b1;
        end
        BR_RET: begin
          nxt = ras_q.pop_back();
          stk = 1'b1;
        end
        default: begin
          table_indices(ip, m_hist, ia, ib, ic);
          tk = tbl_a[ia] ^ tbl_b[ib] ^ tbl_c[ic];
          m_hist = {m_hist[HIST_W-2:0], tk};
          if (tk) nxt = btb_target[bi];
        end
      endcase
    end
  endtask

  task check_fetch;
    logic [ADDR_W-1:0] nxt;
    bit stk;
    int pidx;
    checks++;
    assert (fetch_ip === exp_ip) else begin
      $display("ERR fetch_ip got %h expected %h", fetch_ip, exp_ip);
      errors++;
    end
    pidx = fetch_ip[PAGE_OFS_W +: TRANS_IDX_W];
    if (tlb_known[pidx]) begin
      checks++;
      pa_checks++;
      assert (fetch_pa === {tlb_ppn[pidx], fetch_ip[PAGE_OFS_W-1:0]}) else begin
        $display("ERR fetch_pa got %h expected %h", fetch_pa,
                 {tlb_ppn[pidx], fetch_ip[PAGE_OFS_W-1:0]});
        errors++;
      end
    end
    if (stack_prev) begin   // stack access costs a cycle
      checks++;
      gap_checks++;
      assert (cyc - last_cyc >= 2) else begin
        $display("fetch after a call or return came without the stack access gap");
        errors++;
      end
    end
    predict_next(exp_ip, nxt, stk);
    exp_ip = nxt;
    stack_prev = stk;
    last_cyc = cyc;
    seen++;
  endtask

  always @(negedge clk) begin
    if (rst && cyc > 1) begin
      checks++;
      assert (fetch_valid === 1'b0) else begin
        $display("ERR fetch_valid got %h expected %h", fetch_valid, 1'b0);
        errors++;
      end
    end
    if (!rst && mon_on && fetch_valid === 1'b1) begin
      if (!synced && fetch_ip === sync_ip) begin
        synced = 1'b1;
        exp_ip = sync_ip;
        stack_prev = 1'b0;
      end
      if (synced) check_fetch();
    end
  end

  task retire(input logic [ADDR_W-1:0] ip, input branch_kind_t kind, input logic taken,
              input logic [ADDR_W-1:0] target, input logic [HIST_W-1:0] hist,
              input logic mispred);
    int bi;
    logic [PRED_IDX_W-1:0] ia, ib, ic;
    ret_valid = 1'b1;
    ret_ip = ip;
    ret_kind = kind;
    ret_taken = taken;
    ret_target = target;
    ret_history = hist;
    ret_mispred = mispred;
    step();
    ret_valid = 1'b0;
    ret_mispred = 1'b0;
    bi = ip[OFS_W +: BTB_IDX_W];
    btb_valid[bi] = 1'b1;
    btb_tag[bi] = ip[ADDR_W-1:OFS_W+BTB_IDX_W];
    btb_kind[bi] = kind;
    btb_target[bi] = target;
    if (mispred) begin
      if (kind == BR_COND) begin
        table_indices(ip, hist, ia, ib, ic);
        case (rot)
          0:       tbl_a[ia] = ~tbl_a[ia];
          1:       tbl_b[ib] = ~tbl_b[ib];
          default: tbl_c[ic] = ~tbl_c[ic];
        endcase
        rot = (rot + 1) % 3;
      end
      m_hist = {hist[HIST_W-2:0], taken};
    end
  endtask

  task wait_sync;
    int n;
    n = 0;
    while (!synced && n < 100) begin
      step();
      n++;
    end
    if (!synced) begin
      $display("fetch never reached %h after the redirect", sync_ip);
      errors++;
    end
  endtask

  task wait_fetches(input int n);
    int goal, t;
    goal = seen + n;
    t = 0;
    while (seen < goal && t < 400) begin
      step();
      t++;
    end
    if (seen < goal) begin
      $display("timed out waiting for %0d checked fetches", n);
      errors++;
    end
  endtask

  task redirect_and_sync(input logic [ADDR_W-1:0] ip, input branch_kind_t kind,
                         input logic taken, input logic [ADDR_W-1:0] target,
                         input logic [HIST_W-1:0] hist, input logic [ADDR_W-1:0] land);
    mon_on = 1'b0;
    synced = 1'b0;
    sync_ip = land;
    retire(ip, kind, taken, target, hist, 1'b1);
    mon_on = 1'b1;   // one stale fetch may still come out
    wait_sync();
  endtask

  task reposition(input logic [ADDR_W-1:0] land);
    redirect_and_sync(SCRATCH_IP, BR_JUMP, 1'b1, land, '0, land);
  endtask

  task tlb_write(input logic [VPN_W-1:0] wvpn, input logic [PPN_W-1:0] wppn);
    int idx;
    idx = wvpn[TRANS_IDX_W-1:0];
    repeat (2) step();   // settle
    tlb_known[idx] = 1'b0;
    tlb_wr_valid = 1'b1;
    tlb_wr_vpn = wvpn;
    tlb_wr_ppn = wppn;
    step();
    tlb_wr_valid = 1'b0;
    repeat (2) step();
    tlb_ppn[idx] = wppn;
    tlb_known[idx] = 1'b1;
  endtask

  task expect_reached(input bit ok, input string what);
    checks++;
    assert (ok) else begin
      $display("%s", what);
      errors++;
    end
  endtask

  task end_test(input string name);
    $display("%s: %s", name, (errors == test_err0) ? "ok" : "failed");
    test_err0 = errors;
  endtask

  initial begin
    seed = 32'h268141e2;
    rst = 1'b1;
    init_ip = INIT_IP;
    tlb_wr_valid = 1'b0;
    tlb_wr_vpn = '0;
    tlb_wr_ppn = '0;
    ret_valid = 1'b0;
    ret_ip = '0;
    ret_kind = BR_COND;
    ret_taken = 1'b0;
    ret_target = '0;
    ret_history = '0;
    ret_mispred = 1'b0;
    mon_on = 1'b1;
    synced = 1'b1;   // first fetch must be init_ip
    exp_ip = INIT_IP;
    repeat (8) @(posedge clk);
    #1 rst = 1'b0;

    wait_fetches(20);
    pa0 = pa_checks;
    rnd = {$random(seed), $random(seed)};
    tlb_write(INIT_IP[ADDR_W-1:PAGE_OFS_W], rnd[PPN_W-1:0]);
    wait_fetches(10);
    expect_reached(pa_checks > pa0, "no fetch_pa was compared in the first page");
    end_test("reset and sequential fetch");

    rnd = {$random(seed), $random(seed)};
    vpn = rnd[VPN_W-1:0];
    rnd = {$random(seed), $random(seed)};
    tlb_write(vpn, rnd[PPN_W-1:0]);   // stream runs on across the stall
    wait_fetches(5);
    pa0 = pa_checks;
    reposition({vpn, 12'h080});
    wait_fetches(8);
    expect_reached(pa_checks >= pa0 + 8, "fetches in the written page were not compared");
    end_test("translation write");

    redirect_and_sync(JMP_IP, BR_JUMP, 1'b1, JMP_TGT, '0, JMP_TGT);
    wait_fetches(4);
    reposition(JMP_IP - 32);
    wait_fetches(6);
    end_test("unconditional jump");

    g0 = gap_checks;
    retire(CALL_IP, BR_CALL, 1'b1, FUNC_IP, '0, 1'b0);
    retire(RETN_IP, BR_RET, 1'b1, '0, '0, 1'b0);
    reposition(CALL_IP - 32);
    wait_fetches(8);
    expect_reached(gap_checks >= g0 + 2, "fetches after the call and return were not reached");
    end_test("call and return");

    retire(COND_IP, BR_COND, 1'b1, COND_TGT, '0, 1'b0);   // entry only
    reposition(COND_IP - 32);
    wait_fetches(5);
    for (r = 0; r < 3; r++) begin
      redirect_and_sync(COND_IP, BR_COND, 1'b1, COND_TGT, 8'h01, COND_TGT);
      reposition(COND_IP - 32);
      wait_fetches(5);
    end
    end_test("conditional training");

    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: tb.f
hw/frontend_pkg.sv
hw/link_mem_if.sv
hw/link_mem.sv
hw/link_arbiter.sv
hw/page_translator.sv
hw/return_stack.sv
hw/branch_target_buffer.sv
hw/direction_predictor.sv
hw/fetch_frontend.sv
testbench/tb_fetch_frontend.sv

// File: Bender.yml
package:
  name: fetch_frontend

sources:
  - hw/frontend_pkg.sv
  - hw/link_mem_if.sv
  - hw/link_mem.sv
  - hw/link_arbiter.sv
  - hw/page_translator.sv
  - hw/return_stack.sv
  - hw/branch_target_buffer.sv
  - hw/direction_predictor.sv
  - hw/fetch_frontend.sv
  - target: simulation
    files:
      - testbench/tb_fetch_frontend.sv
